//--- dv/tb_loader_tests.svh
// Directed tests, included inside the testbench module
// Cartridge images start at byte address 0, words are little-endian byte pairs
// Counts are taken from marks so the capture queues are never cleared
`ifndef TB_LOADER_TESTS_SVH
`define TB_LOADER_TESTS_SVH

int bios_mark;
int cheat_mark;
int rom_mark;
int clear_mark;

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	assert (got == exp) else begin
		errors++;
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

// Fill data, mixes every address bit
function automatic logic [15:0] fill_word(input logic [`LD_ADDR_W-1:0] a);
	return (a[15:0] * 16'h9E37) ^ {5'd0, a[26:16]} ^ 16'h3C5A;
endfunction

// Image byte with an optional title and flash marker placed on top of the fill
function automatic logic [7:0] image_byte(input logic [`LD_ADDR_W-1:0] a,
	input logic [95:0] title, input int marker_at);
	logic [71:0] marker;
	logic [15:0] w;
	int          ai;
	marker = "FLASH1M_V";
	w      = fill_word(a);
	ai     = int'(a);
	if (ai >= `LD_TITLE_ADDR && ai < `LD_TITLE_ADDR + `LD_TITLE_LEN)
		return title[8 * (`LD_TITLE_ADDR + `LD_TITLE_LEN - 1 - ai) +: 8];
	if (marker_at >= 0 && ai >= marker_at && ai < marker_at + 9)
		return marker[8 * (marker_at + 8 - ai) +: 8];   // First character on top
	return w[7:0];
endfunction

function automatic logic [15:0] image_word(input logic [`LD_ADDR_W-1:0] a,
	input logic [95:0] title, input int marker_at);
	return {image_byte(a + 27'd1, title, marker_at), image_byte(a, title, marker_at)};
endfunction

task automatic check_reset_values();
	check_value("rom_req", 64'(rom_req), 64'd0);
	check_value("bios_wr", 64'(bios_wr), 64'd0);
	check_value("cheat_valid", 64'(cheat_valid), 64'd0);
	check_value("cheat_clear", 64'(cheat_clear), 64'd0);
	check_value("dl_wait", 64'(dl_wait), 64'd0);
	check_value("cart_status", 64'(cart_status), 64'd0);
endtask

// ============================================================
// Host side of a download
task automatic begin_download(input logic [7:0] index);
	bios_mark  = bios_q.size();
	cheat_mark = cheat_q.size();
	rom_mark   = rom_q.size();
	clear_mark = clear_count;
	@(posedge clk_sys);
	dl_index  <= index;
	dl_active <= 1'b1;
	repeat (2) @(posedge clk_sys);   // dl_start passes before the first write
endtask

task automatic write_word(input logic [`LD_ADDR_W-1:0] addr, input logic [15:0] word);
	@(posedge clk_sys);
	while (dl_wait) @(posedge clk_sys);   // Stall
	dl_addr <= addr;
	dl_word <= word;
	dl_wr   <= 1'b1;
	@(posedge clk_sys);
	dl_wr   <= 1'b0;
endtask

task automatic end_download();
	@(posedge clk_sys);
	while (dl_wait) @(posedge clk_sys);   // Last request acknowledged
	dl_active <= 1'b0;
	repeat (3) @(posedge clk_sys);        // last_addr lands 2 cycles after the fall
endtask

task automatic cart_download(input logic [7:0] index, input logic [95:0] title,
	input int marker_at, input int words);
	logic [`LD_ADDR_W-1:0] a;
	logic [25:0]           exp_addr;
	begin_download(index);
	for (int i = 0; i < words; i++) begin
		a = 27'(2 * i);
		write_word(a, image_word(a, title, marker_at));
	end
	end_download();
	check_value("rom request count", 64'(rom_q.size() - rom_mark), 64'(words));
	for (int i = 0; i < words && rom_mark + i < rom_q.size(); i++) begin
		a        = 27'(2 * i);
		exp_addr = 26'(i) + 26'(`LD_ROM_BASE / 2);   // Halfword address past the ROM base
		check_value("rom_wr.addr", 64'(rom_q[rom_mark + i].addr), 64'(exp_addr));
		check_value("rom_wr.data", 64'(rom_q[rom_mark + i].data),
			64'(image_word(a, title, marker_at)));
	end
	check_value("cart_status.loaded", 64'(cart_status.loaded), 64'd1);
	check_value("cart_status.cart_type", 64'(cart_status.cart_type), 64'(index[7:6]));
	check_value("cart_status.last_addr", 64'(cart_status.last_addr), 64'(2 * (words - 1)));
endtask

// ============================================================
// Tests
task automatic bios_download_test();
	logic [`LD_ADDR_W-1:0] a;
	begin_download(8'd0);
	for (int i = 0; i < 8; i++) write_word(27'h100 + 27'(2 * i), fill_word(27'h100 + 27'(2 * i)));
	end_download();
	check_value("bios_wr count", 64'(bios_q.size() - bios_mark), 64'd4);
	for (int i = 0; i < 4 && bios_mark + i < bios_q.size(); i++) begin
		a = 27'h100 + 27'(4 * i);
		check_value("bios_data.addr", 64'(bios_q[bios_mark + i].addr), 64'(a >> 2));
		check_value("bios_data.data", 64'(bios_q[bios_mark + i].data),
			64'({fill_word(a + 27'd2), fill_word(a)}));   // High halfword on top
	end
	check_value("rom request count", 64'(rom_q.size() - rom_mark), 64'd0);
	check_value("cart_status.loaded", 64'(cart_status.loaded), 64'd0);
endtask

task automatic cart_write_test();
	cart_download(8'h41, 96'h0, -1, 16);
	check_value("cart_status.flash_1m", 64'(cart_status.flash_1m), 64'd0);
endtask

task automatic quirk_test();
	cart_download(8'h82, "DRAGONBALL Z", -1, 88);
	check_value("cart_status.sram_quirk", 64'(cart_status.sram_quirk), 64'd1);
	check_value("cart_status.remap_quirk", 64'(cart_status.remap_quirk), 64'd0);
	cart_download(8'h83, {"CASTLEVANIA", 8'h00}, -1, 88);
	check_value("cart_status.sram_quirk", 64'(cart_status.sram_quirk), 64'd1);
	check_value("cart_status.remap_quirk", 64'(cart_status.remap_quirk), 64'd1);
	cart_download(8'h84, "UNKNOWN GAME", -1, 88);   // Not in the table
	check_value("cart_status.sram_quirk", 64'(cart_status.sram_quirk), 64'd0);
	check_value("cart_status.remap_quirk", 64'(cart_status.remap_quirk), 64'd0);
	check_value("cart_status.flash_1m", 64'(cart_status.flash_1m), 64'd0);
endtask

task automatic flash_test();
	cart_download(8'hC3, "UNKNOWN GAME", 33, 32);   // Marker from byte 33, odd
	check_value("cart_status.flash_1m", 64'(cart_status.flash_1m), 64'd1);
	check_value("cart_status.sram_quirk", 64'(cart_status.sram_quirk), 64'd0);
endtask

task automatic cheat_test();
	logic [`LD_ADDR_W-1:0]   b;
	loader_pkg::cheat_code_t code;
	begin_download(8'd255);
	for (int i = 0; i < 16; i++) write_word(27'(2 * i), fill_word(27'(2 * i)));
	end_download();
	check_value("cheat_clear count", 64'(clear_count - clear_mark), 64'd1);
	check_value("cheat_valid count", 64'(cheat_q.size() - cheat_mark), 64'd2);
	for (int c = 0; c < 2 && cheat_mark + c < cheat_q.size(); c++) begin
		code = cheat_q[cheat_mark + c];
		b    = 27'(16 * c);                          // 16 bytes per code
		check_value("cheat_code.flags", 64'(code.flags),
			64'({fill_word(b + 27'd2), fill_word(b)}));
		check_value("cheat_code.addr", 64'(code.addr),
			64'({fill_word(b + 27'd6), fill_word(b + 27'd4)}));
		check_value("cheat_code.compare", 64'(code.compare),
			64'({fill_word(b + 27'd10), fill_word(b + 27'd8)}));
		check_value("cheat_code.replace", 64'(code.replace),
			64'({fill_word(b + 27'd14), fill_word(b + 27'd12)}));
	end
	check_value("rom request count", 64'(rom_q.size() - rom_mark), 64'd0);
endtask

`endif

//--- dv/tb_rom_loader.sv
// Testbench of the ROM loader front end
// Memory acknowledge comes 0 to 3 cycles after a request is seen
// Needs a simulator with timing and immediate assertions enabled
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module tb_rom_loader;

	localparam int TOTAL_WORDS    = 8 + 16 + 3 * 88 + 32 + 16;  // Words of all tests
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + 400;      // Idle cycles around downloads

	logic                          clk_sys = 1'b0;
	logic                          reset;
	logic                          dl_active;
	logic [`LD_INDEX_W-1:0]        dl_index;
	logic [`LD_ADDR_W-1:0]         dl_addr;
	logic [`LD_WORD_W-1:0]         dl_word;
	logic                          dl_wr;
	logic                          dl_wait;
	logic                          bios_wr;
	loader_pkg::bios_wr_t          bios_data;
	logic                          cheat_valid;
	loader_pkg::cheat_code_t       cheat_code;
	logic                          cheat_clear;
	logic                          rom_req;
	loader_pkg::rom_wr_t           rom_wr;
	logic                          rom_ack = 1'b0;
	loader_pkg::cart_status_t      cart_status;

	int                            errors = 0;          // Failed test checks
	int                            monitor_errors = 0;  // Failed protocol checks
	int                            cycles = 0;
	logic [31:0]                   lfsr = 32'd97969;
	logic [1:0]                    ack_delay = 2'd0;
	logic                          ack_armed = 1'b0;    // Delay drawn for this request
	logic                          pending_q = 1'b0;    // Request open at the last edge
	logic                          acked_q = 1'b0;
	logic                          cart_wr_q = 1'b0;
	loader_pkg::rom_wr_t           held_wr;
	loader_pkg::bios_wr_t          bios_q [$];          // Everything seen on the outputs
	loader_pkg::cheat_code_t       cheat_q [$];
	loader_pkg::rom_wr_t           rom_q [$];
	int                            clear_count = 0;

	always #20 clk_sys = ~clk_sys;   // 40 ns period

	rom_loader_top DUT (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_addr, .dl_word, .dl_wr, .dl_wait,
		.bios_wr, .bios_data, .cheat_valid, .cheat_code, .cheat_clear,
		.rom_req, .rom_wr, .rom_ack, .cart_status
	);

	// Galois LFSR, one step per random bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// ============================================================
	// Memory acknowledge model
	always @(posedge clk_sys) begin
		if (reset) begin
			rom_ack   <= 1'b0;
			ack_armed = 1'b0;
		end else if (rom_ack) begin
			rom_ack   <= 1'b0;           // Request drops at this edge
			ack_armed = 1'b0;
		end else if (rom_req && !ack_armed) begin
			lfsr = lfsr_step(lfsr);
			ack_delay[0] = lfsr[0];
			lfsr = lfsr_step(lfsr);
			ack_delay[1] = lfsr[0];
			ack_armed = 1'b1;
			if (ack_delay == 2'd0) rom_ack <= 1'b1;
		end else if (ack_armed && ack_delay != 2'd0) begin
			ack_delay = ack_delay - 2'd1;
			if (ack_delay == 2'd0) rom_ack <= 1'b1;
		end
	end

	// ============================================================
	// Output capture and handshake rules
	always @(posedge clk_sys) begin
		if (!reset) begin
			if (bios_wr) bios_q.push_back(bios_data);
			if (cheat_valid) cheat_q.push_back(cheat_code);
			if (cheat_clear) clear_count++;
			if (rom_req && rom_ack) rom_q.push_back(rom_wr);   // Accepted write
			if (pending_q) begin
				assert (rom_req && rom_wr == held_wr) else begin
					monitor_errors++;
					$display("ROM request or its data changed before rom_ack");
				end
			end
			assert (!rom_req || dl_wait) else begin
				monitor_errors++;
				$display("dl_wait was low while a ROM request was pending");
			end
			assert (!acked_q || !dl_wait) else begin
				monitor_errors++;
				$display("dl_wait still high one cycle after rom_ack");
			end
			assert (!cart_wr_q || dl_wait) else begin
				monitor_errors++;
				$display("dl_wait low one cycle after a cartridge write");
			end
			assert (!dl_wr || !dl_wait) else begin
				monitor_errors++;
				$display("Host wrote while dl_wait was high");
			end
		end
		pending_q = !reset && rom_req && !rom_ack;
		acked_q   = !reset && rom_req && rom_ack;
		cart_wr_q = !reset && dl_wr && dl_index != `LD_INDEX_W'(`LD_INDEX_BIOS)
			&& dl_index != `LD_INDEX_W'(`LD_INDEX_CHEAT);
		held_wr   = rom_wr;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, %0d test errors, %0d protocol errors",
				cycles, errors, monitor_errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	`include "tb_loader_tests.svh"

	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_word   = '0;
		dl_wr     = 1'b0;
		repeat (2) @(posedge clk_sys);
		check_reset_values();
		reset <= 1'b0;
		bios_download_test();
		cart_write_test();
		quirk_test();
		flash_test();
		cheat_test();
		$display("Run finished, %0d test errors, %0d protocol errors", errors, monitor_errors);
		if (errors == 0 && monitor_errors == 0) $display("*** TEST PASSED ***");
		else $display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/cart_header_scan.sv
// Reads the cartridge header while the image streams in
// Flash marker may sit at any byte alignment in the image
// Quirk lookup covers only the titles of loader_pkg::quirk_table
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module cart_header_scan (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire logic                   beat_valid,
	input  wire loader_pkg::dl_beat_t   beat,
	input  wire logic                   dl_start,
	input  wire logic                   dl_end,
	input  wire logic [`LD_INDEX_W-1:0] dl_index,
	output loader_pkg::cart_status_t    cart_status
);

	localparam logic [`LD_ADDR_W-1:0] TITLE_ADDR = `LD_TITLE_ADDR;
	localparam int                    TITLE_W    = `LD_TITLE_LEN * 8;

	logic                  cart_idx;     // Index names a cartridge
	logic                  cart_dl;      // Running download is a cartridge
	logic                  cart_beat;
	logic [`LD_ADDR_W-1:0] title_off;    // Byte offset from the title start
	logic                  title_hit;
	logic                  title_done;   // Word just after the title
	logic [15:0]           swapped;      // Word in stream byte order
	logic [63:0]           history;      // Previous eight header bytes
	logic [TITLE_W-1:0]    title;
	logic                  q_sram;
	logic                  q_remap;
	logic                  marker;
	int                    title_lsb;

	assign cart_idx   = dl_index != `LD_INDEX_W'(`LD_INDEX_BIOS)
		&& dl_index != `LD_INDEX_W'(`LD_INDEX_CHEAT);
	assign cart_beat  = beat_valid && beat.kind == loader_pkg::kind_cart;
	assign swapped    = {beat.word[7:0], beat.word[15:8]};
	assign title_off  = beat.addr - TITLE_ADDR;
	assign title_hit  = cart_beat && beat.addr >= TITLE_ADDR
		&& title_off < `LD_ADDR_W'(`LD_TITLE_LEN);
	assign title_done = cart_beat && beat.addr == TITLE_ADDR + `LD_ADDR_W'(`LD_TITLE_LEN);

	// Marker ends on the low byte or on the high byte of this word
	assign marker = {history, beat.word[7:0]} == "FLASH1M_V"
		|| {history[55:0], swapped} == "FLASH1M_V";

	// First character lands in the top byte
	always_comb begin
		title_lsb = (`LD_TITLE_LEN - 2 - int'(title_off[3:0])) * 8;
	end

	// ============================================================
	// Quirk table lookup
	always_comb begin
		q_sram  = 1'b0;
		q_remap = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (title == loader_pkg::quirk_table[i].title) begin
				q_sram  = q_sram | loader_pkg::quirk_table[i].sram;
				q_remap = q_remap | loader_pkg::quirk_table[i].remap;
			end
		end
	end

	// Header byte history and title text
	always_ff @(posedge clk_sys) begin
		if (dl_start) history <= '0;                  // No match across images
		else if (cart_beat) history <= {history[47:0], swapped};
		if (title_hit) title[title_lsb +: 16] <= swapped;
	end

	// ============================================================
	// Status
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cart_status <= '0;
			cart_dl     <= 1'b0;
		end else begin
			if (dl_start) begin
				cart_dl <= cart_idx;
				if (cart_idx) begin
					cart_status.loaded      <= 1'b1;
					cart_status.cart_type   <= dl_index[`LD_INDEX_W-1 -: 2];
					cart_status.flash_1m    <= 1'b0;
					cart_status.sram_quirk  <= 1'b0;
					cart_status.remap_quirk <= 1'b0;
				end
			end
			if (cart_beat && marker) cart_status.flash_1m <= 1'b1;
			if (title_done) begin                      // Title complete
				cart_status.sram_quirk  <= q_sram;
				cart_status.remap_quirk <= q_remap;
			end
			if (dl_end && cart_dl) cart_status.last_addr <= beat.addr;
		end
	end

endmodule

`default_nettype wire

//--- hw/download_decode.sv
// Decode stage of the host download stream
// Kind is fixed at the start of a download and dropped at its end
// Host must keep dl_index stable while dl_active is high
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module download_decode (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire logic                   dl_active,
	input  wire logic [`LD_INDEX_W-1:0] dl_index,
	input  wire logic [`LD_ADDR_W-1:0]  dl_addr,
	input  wire logic [`LD_WORD_W-1:0]  dl_word,
	input  wire logic                   dl_wr,
	output logic                        beat_valid,
	output loader_pkg::dl_beat_t        beat,
	output logic                        dl_start,
	output logic                        dl_end,
	output logic                        cheat_clear
);

	logic                 active_q;     // dl_active one cycle late
	logic                 rise;
	loader_pkg::dl_kind_t kind_q;       // Kind of the running download
	loader_pkg::dl_kind_t kind_now;     // Kind seen by this cycle's write
	loader_pkg::dl_kind_t index_kind;

	assign rise = dl_active & ~active_q;

	// Index to kind
	always_comb begin
		if (dl_index == `LD_INDEX_W'(`LD_INDEX_BIOS)) index_kind = loader_pkg::kind_bios;
		else if (dl_index == `LD_INDEX_W'(`LD_INDEX_CHEAT)) index_kind = loader_pkg::kind_cheat;
		else index_kind = loader_pkg::kind_cart;
	end

	// A write in the first active cycle already gets the new kind
	assign kind_now = rise ? index_kind : kind_q;

	// ============================================================
	// Control state
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			active_q    <= 1'b0;
			kind_q      <= loader_pkg::kind_none;
			dl_start    <= 1'b0;
			dl_end      <= 1'b0;
			cheat_clear <= 1'b0;
			beat_valid  <= 1'b0;
		end else begin
			active_q    <= dl_active;
			dl_start    <= rise;
			dl_end      <= ~dl_active & active_q;   // Falling edge
			cheat_clear <= rise && index_kind == loader_pkg::kind_cheat;
			beat_valid  <= dl_wr;
			if (!dl_active) kind_q <= loader_pkg::kind_none;
			else kind_q <= kind_now;
		end
	end

	// Beat register, holds the last write
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			beat.word <= dl_word;
			beat.addr <= dl_addr;
			beat.kind <= kind_now;
		end
	end

	// Host writes only inside a download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> dl_active);

endmodule

`default_nettype wire

//--- hw/loader_pkg.sv
// Types shared by the ROM loader blocks
// Field widths come from loader_settings.svh
// The quirk table holds four titles only
`default_nettype none
`include "loader_settings.svh"

package loader_pkg;

	// Kind of the running download
	typedef enum logic [1:0] {
		kind_none,
		kind_bios,
		kind_cart,
		kind_cheat
	} dl_kind_t;

	// One host write, as registered by the decode stage
	typedef struct packed {
		logic [`LD_WORD_W-1:0] word;  // Raw host word
		logic [`LD_ADDR_W-1:0] addr;  // Byte address
		dl_kind_t              kind;
	} dl_beat_t;

	// Firmware write, one 32-bit word
	typedef struct packed {
		logic [11:0] addr;            // Word address
		logic [31:0] data;
	} bios_wr_t;

	// Cheat code, big-endian field order
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Cartridge ROM write, halfword addressed
	typedef struct packed {
		logic [`LD_ADDR_W-2:0] addr;  // Includes the ROM base
		logic [`LD_WORD_W-1:0] data;
	} rom_wr_t;

	// Game title and the quirks it needs
	typedef struct packed {
		logic [`LD_TITLE_LEN*8-1:0] title;  // First character in the top byte
		logic                       sram;   // SRAM must stay disabled
		logic                       remap;  // Memory remap needed
	} quirk_entry_t;

	// Cartridge results, valid after a cart download
	typedef struct packed {
		logic                  loaded;
		logic [1:0]            cart_type;    // Top index bits
		logic                  flash_1m;
		logic                  sram_quirk;
		logic                  remap_quirk;
		logic [`LD_ADDR_W-1:0] last_addr;    // Last byte address written
	} cart_status_t;

	// Short titles are padded with zero bytes
	localparam quirk_entry_t quirk_table [4] = '{
		'{title: "ROCKY BOXING",           sram: 1'b1, remap: 1'b0},
		'{title: "DRAGONBALL Z",           sram: 1'b1, remap: 1'b0},
		'{title: {"CASTLEVANIA", 8'h00},   sram: 1'b1, remap: 1'b1},
		'{title: {"ZELDA 1", 40'h0},       sram: 1'b1, remap: 1'b1}
	};

endpackage

`default_nettype wire

//--- hw/loader_settings.svh
// Widths, index codes and header offsets of the ROM loader
// Index codes follow the host downloader, all other indexes are cartridges
// ROM base is a byte offset and must be even
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// ============================================================
// Download stream
`define LD_WORD_W      16       // Host word width
`define LD_ADDR_W      27       // Byte address width
`define LD_INDEX_W     8        // Download index width

`define LD_INDEX_BIOS  0        // Firmware image
`define LD_INDEX_CHEAT 255      // Cheat code list

// ============================================================
// Memory map and cartridge header
`define LD_ROM_BASE    786432   // 0xC0000, ROM start in memory
`define LD_TITLE_ADDR  160      // First title byte in the header
`define LD_TITLE_LEN   12       // Title characters

`endif

//--- hw/rom_loader_top.sv
// ROM download front end: decode, execute units and header scan
// The host obeys dl_wait before each write
// Firmware address covers a 16 KiB image
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module rom_loader_top (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire logic                   dl_active,
	input  wire logic [`LD_INDEX_W-1:0] dl_index,
	input  wire logic [`LD_ADDR_W-1:0]  dl_addr,
	input  wire logic [`LD_WORD_W-1:0]  dl_word,
	input  wire logic                   dl_wr,
	output logic                        dl_wait,
	output logic                        bios_wr,
	output loader_pkg::bios_wr_t        bios_data,
	output logic                        cheat_valid,
	output loader_pkg::cheat_code_t     cheat_code,
	output logic                        cheat_clear,
	output logic                        rom_req,
	output loader_pkg::rom_wr_t         rom_wr,
	input  wire logic                   rom_ack,
	output loader_pkg::cart_status_t    cart_status
);

	logic                  beat_valid;
	loader_pkg::dl_beat_t  beat;
	logic                  dl_start;
	logic                  dl_end;
	logic [31:0]           bios_word;
	logic [`LD_ADDR_W-1:0] bios_addr;    // Byte address of the high halfword

	// ============================================================
	// Decode
	download_decode u_decode (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_addr, .dl_word, .dl_wr,
		.beat_valid, .beat, .dl_start, .dl_end, .cheat_clear
	);

	// Execute
	word_assembler #(
		.payload_t(logic [31:0]), .LAST_OFFSET(2), .ACCEPT_KIND(loader_pkg::kind_bios)
	) u_bios (
		.clk_sys, .reset, .beat_valid, .beat,
		.out_valid(bios_wr), .out_payload(bios_word), .out_addr(bios_addr)
	);

	assign bios_data = '{addr: bios_addr[13:2], data: bios_word};

	word_assembler #(
		.payload_t(loader_pkg::cheat_code_t), .LAST_OFFSET(14),
		.ACCEPT_KIND(loader_pkg::kind_cheat)
	) u_cheat (
		.clk_sys, .reset, .beat_valid, .beat,
		.out_valid(cheat_valid), .out_payload(cheat_code), .out_addr()
	);

	rom_write_port u_rom (
		.clk_sys, .reset, .beat_valid, .beat, .rom_req, .rom_wr, .rom_ack, .dl_wait
	);

	// Result
	cart_header_scan u_scan (
		.clk_sys, .reset, .beat_valid, .beat, .dl_start, .dl_end, .dl_index, .cart_status
	);

endmodule

`default_nettype wire

//--- hw/rom_write_port.sv
// Cartridge beats to ROM memory writes at the ROM base
// One request in flight, the host is stalled until it is acknowledged
// rom_ack is taken only while rom_req is high
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module rom_write_port (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire logic                 beat_valid,
	input  wire loader_pkg::dl_beat_t beat,
	output logic                      rom_req,
	output loader_pkg::rom_wr_t       rom_wr,
	input  wire logic                 rom_ack,
	output logic                      dl_wait
);

	// ROM base as a halfword address
	localparam logic [`LD_ADDR_W-2:0] ROM_BASE_HW = (`LD_ADDR_W-1)'(`LD_ROM_BASE / 2);

	logic cart_beat;

	assign cart_beat = beat_valid && beat.kind == loader_pkg::kind_cart;

	// Stall from the beat register until the request is done
	assign dl_wait = cart_beat | rom_req;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) rom_req <= 1'b0;
		else if (cart_beat) rom_req <= 1'b1;
		else if (rom_ack) rom_req <= 1'b0;    // Held until memory takes it
	end

	always_ff @(posedge clk_sys) begin
		if (cart_beat) begin
			rom_wr.addr <= beat.addr[`LD_ADDR_W-1:1] + ROM_BASE_HW;
			rom_wr.data <= beat.word;
		end
	end

	// Pending request keeps its values
	a_req_stable: assert property (@(posedge clk_sys) disable iff (reset)
		rom_req && !rom_ack |=> rom_req && $stable(rom_wr));

endmodule

`default_nettype wire

//--- hw/word_assembler.sv
// Gathers 16-bit beats of one download kind into a wider payload
// 32-bit words of the payload are big-endian, halfwords inside a word little-endian
// payload_t must be a multiple of 32 bits, groups are aligned to its byte size
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module word_assembler #(
	parameter type                  payload_t   = logic [31:0],
	parameter int                   LAST_OFFSET = 2,   // Byte offset of the closing halfword
	parameter loader_pkg::dl_kind_t ACCEPT_KIND = loader_pkg::kind_bios
) (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  beat_valid,
	input  wire loader_pkg::dl_beat_t  beat,
	output logic                       out_valid,
	output payload_t                   out_payload,
	output logic [`LD_ADDR_W-1:0]      out_addr      // Byte address of the closing beat
);

	localparam int PAYLOAD_W = $bits(payload_t);
	localparam int NUM_WORDS = PAYLOAD_W / 32;
	localparam int OFF_W     = $clog2(PAYLOAD_W / 8);

	logic [PAYLOAD_W-1:0] acc;        // Collected halfwords
	logic [OFF_W-1:0]     offset;     // Byte offset inside the group
	logic                 take;
	logic                 last;
	int                   slot_lsb;

	assign take   = beat_valid && beat.kind == ACCEPT_KIND;
	assign offset = beat.addr[OFF_W-1:0];
	assign last   = take && offset == OFF_W'(LAST_OFFSET);

	// Slot of this halfword, first 32-bit word at the top
	always_comb begin
		slot_lsb = (NUM_WORDS - 1 - int'(offset >> 2)) * 32 + (offset[1] ? 16 : 0);
	end

	always_ff @(posedge clk_sys) begin
		if (take) acc[slot_lsb +: 16] <= beat.word;
		if (last) out_addr <= beat.addr;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) out_valid <= 1'b0;
		else out_valid <= last;    // One cycle after the closing beat
	end

	assign out_payload = payload_t'(acc);

	// Closing beats are never back to back
	a_single_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		out_valid |=> !out_valid);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the ROM loader testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rom_loader \
	-f src.f -Mdir obj_dir -o sim_rom_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_rom_loader > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error"
	cat sim.log
	exit 1
fi
cat sim.log

if grep -qx '\*\*\* TEST PASSED \*\*\*' sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

//--- src.f
+incdir+hw
+incdir+dv
hw/loader_pkg.sv
hw/download_decode.sv
hw/word_assembler.sv
hw/rom_write_port.sv
hw/cart_header_scan.sv
hw/rom_loader_top.sv
dv/tb_rom_loader.sv
